// ==== Makefile ====
# Verilator build and run for the integer execute unit testbench

VERILATOR   ?= verilator
TOP         ?= tb_int_core
FILELIST    ?= list.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== exec_pipe.sv ====
`timescale 1ns/1ps
//==================================================
// instruction queue with credit flow control on both sides,
// issues register reads and writes back one cycle later
//==================================================
module exec_pipe #(
  parameter int width_p       = 32,
  parameter int in_depth_p    = 4,
  parameter int out_credits_p = 2
) (
  input  logic                                      clk_i,
  input  logic                                      reset_i,

  input  logic                                      in_v_i,
  input  int_core_pkg::int_instr_s                  in_instr_i,
  output logic                                      in_credit_o,

  output logic                                      result_v_o,
  output int_core_pkg::int_result_s                 result_o,
  input  logic                                      out_credit_i,

  output logic                                      r0_v_o,
  output logic [int_core_pkg::reg_addr_width_c-1:0] r0_addr_o,
  output logic                                      r1_v_o,
  output logic [int_core_pkg::reg_addr_width_c-1:0] r1_addr_o,
  input  logic [width_p-1:0]                        r0_data_i,
  input  logic [width_p-1:0]                        r1_data_i,
  output logic                                      w_v_o,
  output logic [int_core_pkg::reg_addr_width_c-1:0] w_addr_o,
  output logic [width_p-1:0]                        w_data_o,

  output int_core_pkg::int_op_e                     alu_op_o,
  output logic [width_p-1:0]                        alu_a_o,
  output logic [width_p-1:0]                        alu_b_o,
  output logic [int_core_pkg::imm_width_c-1:0]      alu_imm_o,
  input  logic [width_p-1:0]                        alu_result_i
);

  localparam int ptr_width_lp    = (in_depth_p > 1) ? $clog2(in_depth_p) : 1;
  localparam int cnt_width_lp    = $clog2(in_depth_p + 1);
  localparam int credit_width_lp = $clog2(out_credits_p + 1);

  function automatic logic [ptr_width_lp-1:0] ptr_next(input logic [ptr_width_lp-1:0] ptr);
    logic [ptr_width_lp-1:0] last;
    last = ptr_width_lp'(in_depth_p - 1);
    ptr_next = (ptr == last) ? '0 : ptr + 1'b1;
  endfunction

  // ==================================================
  // queue and issue
  // ==================================================

  int_core_pkg::int_instr_s   queue_r [in_depth_p];
  int_core_pkg::int_instr_s   head_instr;
  logic [ptr_width_lp-1:0]    head_r;
  logic [ptr_width_lp-1:0]    tail_r;
  logic [cnt_width_lp-1:0]    count_r;
  logic [credit_width_lp-1:0] credit_r;
  logic                       issue;

  assign head_instr = queue_r[head_r];
  assign issue      = (count_r != '0) && (credit_r != '0);

  // popping the head frees one slot upstream
  assign in_credit_o = issue;
  assign r0_v_o      = issue;
  assign r0_addr_o   = head_instr.rs1;
  assign r1_v_o      = issue;
  assign r1_addr_o   = head_instr.rs2;

  always_ff @(posedge clk_i) begin
    if (in_v_i) begin
      queue_r[tail_r] <= in_instr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_r   <= '0;
      tail_r   <= '0;
      count_r  <= '0;
      credit_r <= credit_width_lp'(out_credits_p);
    end else begin
      if (in_v_i) begin
        tail_r <= ptr_next(tail_r);
      end
      if (issue) begin
        head_r <= ptr_next(head_r);
      end
      if (in_v_i && !issue) begin
        count_r <= count_r + 1'b1;
      end else if (!in_v_i && issue) begin
        count_r <= count_r - 1'b1;
      end
      if (out_credit_i && !issue) begin
        credit_r <= credit_r + 1'b1;
      end else if (!out_credit_i && issue) begin
        credit_r <= credit_r - 1'b1;
      end
    end
  end

  // ==================================================
  // execute and writeback
  // ==================================================

  logic                                      ex_v_r;
  int_core_pkg::int_op_e                     ex_op_r;
  logic [int_core_pkg::reg_addr_width_c-1:0] ex_rd_r;
  logic [int_core_pkg::imm_width_c-1:0]      ex_imm_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_v_r <= 1'b0;
    end else begin
      ex_v_r <= issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      ex_op_r  <= head_instr.op;
      ex_rd_r  <= head_instr.rd;
      ex_imm_r <= head_instr.imm;
    end
  end

  // operands come straight from the register file read ports
  assign alu_op_o  = ex_op_r;
  assign alu_a_o   = r0_data_i;
  assign alu_b_o   = r1_data_i;
  assign alu_imm_o = ex_imm_r;

  // rd 0 still reports its value but is not stored
  assign w_v_o          = ex_v_r && (ex_rd_r != '0);
  assign w_addr_o       = ex_rd_r;
  assign w_data_o       = alu_result_i;
  assign result_v_o     = ex_v_r;
  assign result_o.rd    = ex_rd_r;
  assign result_o.value = alu_result_i;

  // sender must hold a credit, so a push never finds the queue full
  assert property (@(posedge clk_i) disable iff (reset_i)
    in_v_i |-> (count_r < cnt_width_lp'(in_depth_p)))
    else $error("instruction queue overflow");

  // receiver never returns more credits than it was given
  assert property (@(posedge clk_i) disable iff (reset_i)
    (out_credit_i && !issue) |-> (credit_r < credit_width_lp'(out_credits_p)))
    else $error("output credit counter overflow");

endmodule

// ==== int_alu.sv ====
`timescale 1ns/1ps
//==================================================
// single-cycle integer alu, result selected by opcode
//==================================================
module int_alu #(
  parameter int width_p = 32
) (
  input  int_core_pkg::int_op_e                op_i,
  input  logic [width_p-1:0]                   a_i,
  input  logic [width_p-1:0]                   b_i,
  input  logic [int_core_pkg::imm_width_c-1:0] imm_i,
  output logic [width_p-1:0]                   result_o
);

  localparam int shamt_width_lp = $clog2(width_p);
  localparam int ext_width_lp   = width_p - int_core_pkg::imm_width_c;

  logic [width_p-1:0]        imm_ext;
  logic [shamt_width_lp-1:0] shamt;

  // sign extension of the immediate
  assign imm_ext = {{ext_width_lp{imm_i[int_core_pkg::imm_width_c-1]}}, imm_i};

  // only the low bits of b count as shift amount
  assign shamt = b_i[shamt_width_lp-1:0];

  always_comb begin
    case (op_i)
      int_core_pkg::OP_ADD: begin
        result_o = a_i + b_i;
      end
      int_core_pkg::OP_SUB: begin
        result_o = a_i - b_i;
      end
      int_core_pkg::OP_AND: begin
        result_o = a_i & b_i;
      end
      int_core_pkg::OP_OR: begin
        result_o = a_i | b_i;
      end
      int_core_pkg::OP_XOR: begin
        result_o = a_i ^ b_i;
      end
      int_core_pkg::OP_SLL: begin
        result_o = a_i << shamt;
      end
      int_core_pkg::OP_SRL: begin
        result_o = a_i >> shamt;
      end
      int_core_pkg::OP_ADDI: begin
        result_o = a_i + imm_ext;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== int_core_pkg.sv ====
//==================================================
// shared opcode, instruction and result types for the
// integer execute unit, referenced by scoped name
//==================================================
package int_core_pkg;

  // ==================================================
  // widths
  // ==================================================

  // default datapath width that the top level passes down
  localparam int data_width_c = 32;

  // 32 architectural registers
  localparam int reg_addr_width_c = 5;

  // immediate field of the instruction word
  localparam int imm_width_c = 16;

  // ==================================================
  // opcodes
  // ==================================================

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_SLL  = 3'd5,
    OP_SRL  = 3'd6,
    OP_ADDI = 3'd7
  } int_op_e;

  // ==================================================
  // instruction and result words
  // ==================================================

  typedef struct packed {
    int_op_e                     op;
    logic [reg_addr_width_c-1:0] rd;
    logic [reg_addr_width_c-1:0] rs1;
    logic [reg_addr_width_c-1:0] rs2;
    // sign-extended by the alu and only used by OP_ADDI
    logic [imm_width_c-1:0]      imm;
  } int_instr_s;

  typedef struct packed {
    logic [reg_addr_width_c-1:0] rd;
    logic [data_width_c-1:0]     value;
  } int_result_s;

endpackage

// ==== int_core_top.sv ====
`timescale 1ns/1ps
//==================================================
// integer execute unit top, sets sizes and wires the
// pipeline, register file and alu together
//==================================================
module int_core_top #(
  parameter int width_p       = int_core_pkg::data_width_c,
  parameter int els_p         = 1 << int_core_pkg::reg_addr_width_c,
  parameter int in_depth_p    = 4,
  parameter int out_credits_p = 2
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      in_v_i,
  input  int_core_pkg::int_instr_s  in_instr_i,
  output logic                      in_credit_o,
  output logic                      result_v_o,
  output int_core_pkg::int_result_s result_o,
  input  logic                      out_credit_i
);

  logic                                      r0_v;
  logic [int_core_pkg::reg_addr_width_c-1:0] r0_addr;
  logic [width_p-1:0]                        r0_data;
  logic                                      r1_v;
  logic [int_core_pkg::reg_addr_width_c-1:0] r1_addr;
  logic [width_p-1:0]                        r1_data;
  logic                                      w_v;
  logic [int_core_pkg::reg_addr_width_c-1:0] w_addr;
  logic [width_p-1:0]                        w_data;
  int_core_pkg::int_op_e                     alu_op;
  logic [width_p-1:0]                        alu_a;
  logic [width_p-1:0]                        alu_b;
  logic [int_core_pkg::imm_width_c-1:0]      alu_imm;
  logic [width_p-1:0]                        alu_result;

  exec_pipe #(
    .width_p       (width_p),
    .in_depth_p    (in_depth_p),
    .out_credits_p (out_credits_p)
  ) pipe (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_v_i       (in_v_i),
    .in_instr_i   (in_instr_i),
    .in_credit_o  (in_credit_o),
    .result_v_o   (result_v_o),
    .result_o     (result_o),
    .out_credit_i (out_credit_i),
    .r0_v_o       (r0_v),
    .r0_addr_o    (r0_addr),
    .r1_v_o       (r1_v),
    .r1_addr_o    (r1_addr),
    .r0_data_i    (r0_data),
    .r1_data_i    (r1_data),
    .w_v_o        (w_v),
    .w_addr_o     (w_addr),
    .w_data_o     (w_data),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_imm_o    (alu_imm),
    .alu_result_i (alu_result)
  );

  regfile_2r1w_bypass #(
    .width_p (width_p),
    .els_p   (els_p)
  ) rf (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .w_v_i     (w_v),
    .w_addr_i  (w_addr),
    .w_data_i  (w_data),
    .r0_v_i    (r0_v),
    .r0_addr_i (r0_addr),
    .r0_data_o (r0_data),
    .r1_v_i    (r1_v),
    .r1_addr_i (r1_addr),
    .r1_data_o (r1_data)
  );

  int_alu #(
    .width_p (width_p)
  ) alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .imm_i    (alu_imm),
    .result_o (alu_result)
  );

endmodule

// ==== list.f ====
int_core_pkg.sv
mem_2r1w_sync.sv
regfile_2r1w_bypass.sv
int_alu.sv
exec_pipe.sv
int_core_top.sv
tb_int_core.sv

// ==== mem_2r1w_sync.sv ====
`timescale 1ns/1ps
//==================================================
// synchronous storage array, one write and two read
// ports, read data registered one cycle after request
//==================================================
module mem_2r1w_sync #(
  parameter int  width_p       = 32,
  parameter int  els_p         = 32,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     w_v_i,
  input  logic [addr_width_lp-1:0] w_addr_i,
  input  logic [width_p-1:0]       w_data_i,

  input  logic                     r0_v_i,
  input  logic [addr_width_lp-1:0] r0_addr_i,
  output logic [width_p-1:0]       r0_data_o,

  input  logic                     r1_v_i,
  input  logic [addr_width_lp-1:0] r1_addr_i,
  output logic [width_p-1:0]       r1_data_o
);

  logic [width_p-1:0] mem_r [els_p];

  // single write port
  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      mem_r[w_addr_i] <= w_data_i;
    end
  end

  // a same-cycle write is not seen by the read ports
  // each output keeps its word until the next valid read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r0_data_o <= '0;
      r1_data_o <= '0;
    end else begin
      if (r0_v_i) begin
        r0_data_o <= mem_r[r0_addr_i];
      end
      if (r1_v_i) begin
        r1_data_o <= mem_r[r1_addr_i];
      end
    end
  end

endmodule

// ==== regfile_2r1w_bypass.sv ====
`timescale 1ns/1ps
//==================================================
// register file around the 2r1w array with a zero register,
// same-cycle write-through and a held last read value
//==================================================
module regfile_2r1w_bypass #(
  parameter int  width_p       = 32,
  parameter int  els_p         = 32,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     w_v_i,
  input  logic [addr_width_lp-1:0] w_addr_i,
  input  logic [width_p-1:0]       w_data_i,

  input  logic                     r0_v_i,
  input  logic [addr_width_lp-1:0] r0_addr_i,
  output logic [width_p-1:0]       r0_data_o,

  input  logic                     r1_v_i,
  input  logic [addr_width_lp-1:0] r1_addr_i,
  output logic [width_p-1:0]       r1_data_o
);

  // ==================================================
  // array access filtering
  // ==================================================

  logic               r0_hit_w;
  logic               r1_hit_w;
  logic               mem_r0_v;
  logic               mem_r1_v;
  logic               mem_w_v;
  logic [width_p-1:0] mem_r0_data;
  logic [width_p-1:0] mem_r1_data;

  // read and write to one address in one cycle
  assign r0_hit_w = w_v_i && r0_v_i && (w_addr_i == r0_addr_i);
  assign r1_hit_w = w_v_i && r1_v_i && (w_addr_i == r1_addr_i);

  // register 0 never touches the array
  assign mem_r0_v = r0_v_i && !r0_hit_w && (r0_addr_i != '0);
  assign mem_r1_v = r1_v_i && !r1_hit_w && (r1_addr_i != '0);
  assign mem_w_v  = w_v_i && (w_addr_i != '0);

  mem_2r1w_sync #(
    .width_p (width_p),
    .els_p   (els_p)
  ) mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .w_v_i     (mem_w_v),
    .w_addr_i  (w_addr_i),
    .w_data_i  (w_data_i),
    .r0_v_i    (mem_r0_v),
    .r0_addr_i (r0_addr_i),
    .r0_data_o (mem_r0_data),
    .r1_v_i    (mem_r1_v),
    .r1_addr_i (r1_addr_i),
    .r1_data_o (mem_r1_data)
  );

  // ==================================================
  // bypass and read hold
  // ==================================================

  logic                     r0_hit_w_r;
  logic                     r1_hit_w_r;
  logic                     r0_v_r;
  logic                     r1_v_r;
  logic [addr_width_lp-1:0] r0_addr_r;
  logic [addr_width_lp-1:0] r1_addr_r;
  logic [width_p-1:0]       bypass_data_r;
  logic [width_p-1:0]       r0_hold_r;
  logic [width_p-1:0]       r1_hold_r;
  logic [width_p-1:0]       r0_fresh;
  logic [width_p-1:0]       r1_fresh;
  logic [width_p-1:0]       r0_cur;
  logic [width_p-1:0]       r1_cur;

  // data returned by last cycle's request
  assign r0_fresh = r0_hit_w_r ? bypass_data_r : mem_r0_data;
  assign r1_fresh = r1_hit_w_r ? bypass_data_r : mem_r1_data;

  assign r0_cur = r0_v_r ? r0_fresh : r0_hold_r;
  assign r1_cur = r1_v_r ? r1_fresh : r1_hold_r;

  assign r0_data_o = (r0_addr_r == '0) ? '0 : r0_cur;
  assign r1_data_o = (r1_addr_r == '0) ? '0 : r1_cur;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r0_hit_w_r <= 1'b0;
      r1_hit_w_r <= 1'b0;
      r0_v_r     <= 1'b0;
      r1_v_r     <= 1'b0;
      r0_addr_r  <= '0;
      r1_addr_r  <= '0;
    end else begin
      r0_hit_w_r <= r0_hit_w;
      r1_hit_w_r <= r1_hit_w;
      r0_v_r     <= r0_v_i;
      r1_v_r     <= r1_v_i;
      if (r0_v_i) begin
        r0_addr_r <= r0_addr_i;
      end
      if (r1_v_i) begin
        r1_addr_r <= r1_addr_i;
      end
    end
  end

  // a later write to the held address replaces the held word
  always_ff @(posedge clk_i) begin
    if (r0_hit_w || r1_hit_w) begin
      bypass_data_r <= w_data_i;
    end
    if (w_v_i && (w_addr_i == r0_addr_r)) begin
      r0_hold_r <= w_data_i;
    end else begin
      r0_hold_r <= r0_cur;
    end
    if (w_v_i && (w_addr_i == r1_addr_r)) begin
      r1_hold_r <= w_data_i;
    end else begin
      r1_hold_r <= r1_cur;
    end
  end

  // write address must be known whenever a write is requested
  assert property (@(posedge clk_i) disable iff (reset_i)
    w_v_i |-> !$isunknown(w_addr_i))
    else $error("regfile write with unknown address");

endmodule

// ==== tb_int_core.sv ====
`timescale 1ns/1ps
//==================================================
// testbench for the integer execute unit, runs a table
// of instructions against a reference register model
//==================================================
module tb_int_core;

  localparam int width_lp       = int_core_pkg::data_width_c;
  localparam int in_depth_lp    = 4;
  localparam int out_credits_lp = 2;
  localparam int idle_limit_lp  = 200;
  localparam int seed_lp        = 32'h52d7_4d0a;

  typedef struct packed {
    logic [2:0]                group;
    logic [7:0]                hold;
    int_core_pkg::int_instr_s  instr;
    int_core_pkg::int_result_s expected;
  } stim_entry_s;

  logic                      clk_i;
  logic                      reset_i;
  logic                      in_v_i;
  int_core_pkg::int_instr_s  in_instr_i;
  logic                      in_credit_o;
  logic                      result_v_o;
  int_core_pkg::int_result_s result_o;
  logic                      out_credit_i;

  stim_entry_s       stim_q [$];
  logic [width_lp-1:0] ref_regs [32];
  int data_errs;
  int proto_errs;
  int timeout_errs;
  int sent_cnt;
  int in_credit_total;
  int result_total;

  int_core_top #(
    .in_depth_p    (in_depth_lp),
    .out_credits_p (out_credits_lp)
  ) UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_v_i       (in_v_i),
    .in_instr_i   (in_instr_i),
    .in_credit_o  (in_credit_o),
    .result_v_o   (result_v_o),
    .result_o     (result_o),
    .out_credit_i (out_credit_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // totals over the whole run
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (in_credit_o) in_credit_total++;
      if (result_v_o) result_total++;
    end
  end

  // ==================================================
  // reference model and table
  // ==================================================

  function automatic logic [width_lp-1:0] model_alu(input int_core_pkg::int_op_e op,
                                                    input logic [width_lp-1:0] a,
                                                    input logic [width_lp-1:0] b,
                                                    input logic [15:0] imm);
    case (op)
      int_core_pkg::OP_ADD:  return a + b;
      int_core_pkg::OP_SUB:  return a - b;
      int_core_pkg::OP_AND:  return a & b;
      int_core_pkg::OP_OR:   return a | b;
      int_core_pkg::OP_XOR:  return a ^ b;
      int_core_pkg::OP_SLL:  return a << b[4:0];
      int_core_pkg::OP_SRL:  return a >> b[4:0];
      default:               return a + {{(width_lp - 16){imm[15]}}, imm};
    endcase
  endfunction

  function automatic string group_name(input logic [2:0] group);
    case (group)
      3'd0:    return "init";
      3'd1:    return "alu";
      3'd2:    return "zero_reg";
      3'd3:    return "bypass";
      3'd4:    return "backpressure";
      default: return "random";
    endcase
  endfunction

  // register 0 of the model is never written
  function automatic void add_entry(input logic [2:0] group, input int_core_pkg::int_op_e op,
                                    input int rd, input int rs1, input int rs2,
                                    input logic [15:0] imm, input int hold);
    stim_entry_s e;
    e.group          = group;
    e.hold           = 8'(hold);
    e.instr.op       = op;
    e.instr.rd       = 5'(rd);
    e.instr.rs1      = 5'(rs1);
    e.instr.rs2      = 5'(rs2);
    e.instr.imm      = imm;
    e.expected.rd    = 5'(rd);
    e.expected.value = model_alu(op, ref_regs[rs1], ref_regs[rs2], imm);
    if (rd != 0) ref_regs[rd] = e.expected.value;
    stim_q.push_back(e);
  endfunction

  function automatic void build_table();
    int r;
    int i;
    int_core_pkg::int_op_e op;
    for (r = 0; r < 32; r++) ref_regs[r] = '0;
    // every register gets a value before anything reads it
    for (r = 1; r < 32; r++) begin
      add_entry(3'd0, int_core_pkg::OP_ADDI, r, 0, 0, 16'(r * 1237 + 2465), 0);
    end
    add_entry(3'd1, int_core_pkg::OP_ADD,  10, 1, 2, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_SUB,  11, 1, 2, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_AND,  12, 3, 4, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_OR,   13, 3, 4, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_XOR,  14, 5, 6, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_ADDI, 15, 7, 0, 16'hfffb, 0);
    add_entry(3'd1, int_core_pkg::OP_ADDI, 16, 0, 0, 16'h8000, 0);
    // shift amounts 31, 32 and 63
    add_entry(3'd1, int_core_pkg::OP_ADDI, 20, 0, 0, 16'd31, 0);
    add_entry(3'd1, int_core_pkg::OP_ADDI, 21, 0, 0, 16'd32, 0);
    add_entry(3'd1, int_core_pkg::OP_ADDI, 22, 0, 0, 16'd63, 0);
    add_entry(3'd1, int_core_pkg::OP_SLL,  17, 5, 20, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_SRL,  18, 16, 20, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_SLL,  19, 5, 21, 16'h0, 0);
    add_entry(3'd1, int_core_pkg::OP_SRL,  23, 16, 22, 16'h0, 0);
    add_entry(3'd2, int_core_pkg::OP_ADD,  24, 0, 0, 16'h0, 0);
    add_entry(3'd2, int_core_pkg::OP_ADDI, 0, 1, 0, 16'd100, 0);
    add_entry(3'd2, int_core_pkg::OP_OR,   25, 0, 3, 16'h0, 0);
    add_entry(3'd2, int_core_pkg::OP_ADD,  26, 0, 0, 16'h0, 0);
    add_entry(3'd3, int_core_pkg::OP_ADDI, 5, 0, 0, 16'd7, 0);
    add_entry(3'd3, int_core_pkg::OP_ADD,  6, 5, 5, 16'h0, 0);
    add_entry(3'd3, int_core_pkg::OP_SUB,  6, 6, 5, 16'h0, 0);
    add_entry(3'd3, int_core_pkg::OP_ADD,  7, 6, 6, 16'h0, 0);
    add_entry(3'd3, int_core_pkg::OP_SLL,  8, 7, 5, 16'h0, 0);
    // both output credits held long enough for the queue to fill
    add_entry(3'd4, int_core_pkg::OP_ADD,  9, 1, 2, 16'h0, 20);
    add_entry(3'd4, int_core_pkg::OP_SUB,  9, 9, 3, 16'h0, 20);
    add_entry(3'd4, int_core_pkg::OP_XOR,  10, 9, 4, 16'h0, 0);
    add_entry(3'd4, int_core_pkg::OP_OR,   11, 10, 9, 16'h0, 0);
    add_entry(3'd4, int_core_pkg::OP_ADDI, 12, 11, 0, 16'hff00, 0);
    add_entry(3'd4, int_core_pkg::OP_AND,  13, 12, 1, 16'h0, 0);
    add_entry(3'd4, int_core_pkg::OP_SLL,  14, 13, 20, 16'h0, 0);
    add_entry(3'd4, int_core_pkg::OP_SRL,  15, 14, 5, 16'h0, 0);
    for (i = 0; i < 200; i++) begin
      op = int_core_pkg::int_op_e'(3'($urandom_range(7, 0)));
      add_entry(3'd5, op, int'($urandom_range(31, 0)), int'($urandom_range(31, 0)),
                int'($urandom_range(31, 0)), 16'($urandom), int'($urandom_range(4, 0)));
    end
  endfunction

  // ==================================================
  // sender and receiver
  // ==================================================

  task automatic send_all();
    int credits;
    int idx;
    int stall;
    credits = in_depth_lp;
    idx = 0;
    stall = 0;
    while (idx < stim_q.size()) begin
      @(posedge clk_i);
      if (in_credit_o) credits++;
      if (credits > in_depth_lp) begin
        $display("more input credits returned than instructions sent");
        proto_errs++;
        credits = in_depth_lp;
      end
      if (credits > 0) begin
        in_v_i     <= 1'b1;
        in_instr_i <= stim_q[idx].instr;
        credits--;
        idx++;
        sent_cnt++;
        stall = 0;
      end else begin
        in_v_i <= 1'b0;
        stall++;
        if (stall > idle_limit_lp) begin
          $display("sender timed out waiting for an input credit");
          timeout_errs++;
          break;
        end
      end
    end
    @(posedge clk_i);
    in_v_i <= 1'b0;
  endtask

  task automatic receive_all();
    int due_q [$];
    int cyc;
    int recv;
    int held;
    int idle;
    stim_entry_s e;
    cyc = 0;
    recv = 0;
    held = 0;
    idle = 0;
    while (recv < stim_q.size() || due_q.size() > 0) begin
      @(posedge clk_i);
      cyc++;
      idle++;
      out_credit_i <= 1'b0;
      if (result_v_o && recv < stim_q.size()) begin
        e = stim_q[recv];
        if (result_o !== e.expected) begin
          $display("Fail %s[%0d]: expected rd %0d value %08h, actual rd %0d value %08h",
                   group_name(e.group), recv, e.expected.rd, e.expected.value,
                   result_o.rd, result_o.value);
          data_errs++;
        end
        recv++;
        held++;
        idle = 0;
        if (held > out_credits_lp) begin
          $display("more results outstanding than output credits granted");
          proto_errs++;
        end
        due_q.push_back(cyc + int'(e.hold));
      end
      // at most one credit per cycle and the oldest goes first
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        out_credit_i <= 1'b1;
        due_q.delete(0);
        held--;
        idle = 0;
      end
      if (idle > idle_limit_lp) begin
        $display("receiver timed out waiting for a result");
        timeout_errs++;
        break;
      end
    end
    @(posedge clk_i);
    out_credit_i <= 1'b0;
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    in_v_i       = 1'b0;
    in_instr_i   = '0;
    out_credit_i = 1'b0;
    reset_i      = 1'b1;
    data_errs    = 0;
    proto_errs   = 0;
    timeout_errs = 0;
    sent_cnt     = 0;
    void'($urandom(seed_lp));
    build_table();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    fork
      send_all();
      receive_all();
    join
    // nothing further may appear in the quiet period
    repeat (8) @(posedge clk_i);
    if (in_credit_total != sent_cnt) begin
      $display("Fail in_credit_count: expected %0d, actual %0d", sent_cnt, in_credit_total);
      proto_errs++;
    end
    if (result_total != stim_q.size()) begin
      $display("Fail result_count: expected %0d, actual %0d", stim_q.size(), result_total);
      proto_errs++;
    end
    $display("errors: data %0d, protocol %0d, timeout %0d", data_errs, proto_errs, timeout_errs);
    if (data_errs + proto_errs + timeout_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
